/* hw/fcvt_config.svh */
// Converter configuration
// Single-precision format widths, exponent bias and int32 saturation values

`ifndef FCVT_CONFIG_SVH
`define FCVT_CONFIG_SVH

// --------------------
// Floating-point format
// --------------------
`define FCVT_EXP_W 8
`define FCVT_MAN_W 23
`define FCVT_BIAS 127

// --------------------
// Integer format
// --------------------
`define FCVT_INT_W 32
// Enough bits to count up to 31 leading zeros
`define FCVT_LZ_W 5

// Saturation values for out-of-range conversions
`define FCVT_INT_MAX 32'h7fff_ffff
`define FCVT_INT_MIN 32'h8000_0000
`define FCVT_UINT_MAX 32'hffff_ffff

`endif

/* hw/fcvt_pkg.sv */
// Converter types
// Vector typedefs for the data widths plus the operation and FSM encodings

`default_nettype none

`include "fcvt_config.svh"

package fcvt_pkg;

  // Integer operand or result
  typedef logic [`FCVT_INT_W-1:0] int_word_t;

  // Packed single-precision word {sign, exponent, mantissa}
  typedef logic [`FCVT_EXP_W+`FCVT_MAN_W:0] fp_word_t;

  typedef logic [`FCVT_EXP_W-1:0] exp_t;
  typedef logic [`FCVT_MAN_W-1:0] man_t;
  typedef logic [`FCVT_LZ_W-1:0] lz_t;

  // Rounding mode
  // 0 nearest-even, 1 toward zero, 2 down, 3 up, 4 nearest-max-magnitude
  typedef logic [2:0] rm_t;

  // Bit 1 selects integer to float, bit 0 selects unsigned
  typedef enum logic [1:0] {
    FCVT_W_S  = 2'b00,
    FCVT_WU_S = 2'b01,
    FCVT_S_W  = 2'b10,
    FCVT_S_WU = 2'b11
  } cvt_op_t;

  typedef enum logic [1:0] {
    IDLE    = 2'b00,
    CONVERT = 2'b01,
    ROUND   = 2'b10,
    DONE    = 2'b11
  } state_t;

endpackage

`default_nettype wire

/* hw/fcvt_norm_if.sv */
// Normalized integer bundle
// Carries sign, exponent, mantissa and the extra rounding bits to the rounder

`timescale 1ns/1ps
`default_nettype none

interface fcvt_norm_if;

  logic              sign;
  fcvt_pkg::exp_t    exponent;
  fcvt_pkg::man_t    mantissa;
  // Bits below the mantissa lsb
  logic              guard;
  logic              round_bit;
  logic              sticky;

  modport producer (
    output sign,
    output exponent,
    output mantissa,
    output guard,
    output round_bit,
    output sticky
  );

  modport consumer (
    input sign,
    input exponent,
    input mantissa,
    input guard,
    input round_bit,
    input sticky
  );

endinterface

`default_nettype wire

/* hw/fcvt_control.sv */
// Converter sequencer
// Four-state FSM stepping through capture, convert, round and done

`timescale 1ns/1ps
`default_nettype none

module fcvt_control (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              start,
  input  fcvt_pkg::cvt_op_t operation,
  output logic              accept,
  output logic              convert_en,
  output logic              round_en,
  output logic              busy,
  output logic              done,
  output fcvt_pkg::cvt_op_t op_q
);

  fcvt_pkg::state_t state;
  fcvt_pkg::state_t state_nxt;

  // Start only counts in IDLE
  assign accept = (state == fcvt_pkg::IDLE) && start;

  always_comb begin
    case (state)
      fcvt_pkg::IDLE:    state_nxt = accept ? fcvt_pkg::CONVERT : fcvt_pkg::IDLE;
      fcvt_pkg::CONVERT: state_nxt = fcvt_pkg::ROUND;
      fcvt_pkg::ROUND:   state_nxt = fcvt_pkg::DONE;
      default:           state_nxt = fcvt_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= fcvt_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Operation stays fixed for the whole conversion
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      op_q <= fcvt_pkg::FCVT_W_S;
    end else if (accept) begin
      op_q <= operation;
    end
  end

  // --------------------
  // State decodes
  // --------------------
  assign convert_en = (state == fcvt_pkg::CONVERT);
  assign round_en   = (state == fcvt_pkg::ROUND);
  assign busy       = convert_en || round_en;
  assign done       = (state == fcvt_pkg::DONE);

endmodule

`default_nettype wire

/* hw/fp_to_int.sv */
// Float to int32 converter
// Truncates toward zero, saturates out-of-range values and flags nv/nx

`timescale 1ns/1ps
`default_nettype none

`include "fcvt_config.svh"

module fp_to_int (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                accept,
  input  logic                convert_en,
  input  logic                is_unsigned,
  input  fcvt_pkg::fp_word_t  fp_operand,
  output fcvt_pkg::int_word_t int_result,
  output logic                flag_nv,
  output logic                flag_nx
);

  fcvt_pkg::fp_word_t  fp_q;
  logic                sign;
  fcvt_pkg::exp_t      exp_f;
  fcvt_pkg::man_t      man_f;
  logic                is_special;
  logic                is_zero;
  logic                below_one;
  fcvt_pkg::exp_t      unb_exp;
  logic [63:0]         fixed;
  fcvt_pkg::int_word_t mag;
  logic                frac_lost;
  logic                ovf_signed;
  logic                ovf_unsigned;
  fcvt_pkg::int_word_t res_d;
  logic                nv_d;
  logic                nx_d;

  always_ff @(posedge clk) begin
    if (accept) begin
      fp_q <= fp_operand;
    end
  end

  // --------------------
  // Field split
  // --------------------
  assign sign  = fp_q[`FCVT_EXP_W+`FCVT_MAN_W];
  assign exp_f = fp_q[`FCVT_EXP_W+`FCVT_MAN_W-1:`FCVT_MAN_W];
  assign man_f = fp_q[`FCVT_MAN_W-1:0];

  // NaN and infinity share the all-ones exponent
  assign is_special = (exp_f == '1);
  assign is_zero    = (exp_f == '0) && (man_f == '0);
  assign below_one  = (exp_f < fcvt_pkg::exp_t'(`FCVT_BIAS));
  assign unb_exp    = exp_f - fcvt_pkg::exp_t'(`FCVT_BIAS);

  // Fixed point with 32 integer and 32 fraction bits, 1.0 sits at bit 32
  assign fixed     = {31'b0, 1'b1, man_f, 9'b0} << unb_exp[4:0];
  assign mag       = fixed[63:32];
  assign frac_lost = |fixed[31:0];

  // -2^31 is the one value with exponent 31 that still fits
  assign ovf_signed   = (unb_exp > 8'd31) || ((unb_exp == 8'd31) && !(sign && man_f == '0));
  assign ovf_unsigned = (unb_exp > 8'd31);

  always_comb begin
    res_d = '0;
    nv_d  = 1'b0;
    nx_d  = 1'b0;
    if (is_special) begin
      nv_d = 1'b1;
      if (is_unsigned) begin
        res_d = sign ? '0 : `FCVT_UINT_MAX;
      end else begin
        res_d = sign ? `FCVT_INT_MIN : `FCVT_INT_MAX;
      end
    end else if (is_zero) begin
      res_d = '0;
    end else if (below_one) begin
      nx_d = 1'b1;
    end else if (is_unsigned) begin
      if (sign) begin
        // Negative of magnitude 1 or more has no unsigned value
        nv_d = 1'b1;
      end else if (ovf_unsigned) begin
        res_d = `FCVT_UINT_MAX;
        nv_d  = 1'b1;
      end else begin
        res_d = mag;
        nx_d  = frac_lost;
      end
    end else if (ovf_signed) begin
      res_d = sign ? `FCVT_INT_MIN : `FCVT_INT_MAX;
      nv_d  = 1'b1;
    end else begin
      res_d = sign ? -mag : mag;
      nx_d  = frac_lost;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      int_result <= '0;
      flag_nv    <= 1'b0;
      flag_nx    <= 1'b0;
    end else if (convert_en) begin
      int_result <= res_d;
      flag_nv    <= nv_d;
      flag_nx    <= nx_d;
    end
  end

endmodule

`default_nettype wire

/* hw/int_to_fp.sv */
// Int32 normalizer
// Takes the magnitude, counts leading zeros and splits it into the
// single-precision fields plus guard, round and sticky bits

`timescale 1ns/1ps
`default_nettype none

`include "fcvt_config.svh"

module int_to_fp (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                accept,
  input  logic                convert_en,
  input  logic                is_unsigned,
  input  fcvt_pkg::int_word_t int_operand,
  fcvt_norm_if.producer       norm
);

  fcvt_pkg::int_word_t int_q;
  logic                neg;
  fcvt_pkg::int_word_t abs_val;
  fcvt_pkg::lz_t       lz;
  fcvt_pkg::int_word_t shifted;
  logic                is_zero;
  fcvt_pkg::exp_t      exp_d;

  always_ff @(posedge clk) begin
    if (accept) begin
      int_q <= int_operand;
    end
  end

  // --------------------
  // Sign and magnitude
  // --------------------
  assign neg     = !is_unsigned && int_q[`FCVT_INT_W-1];
  // Most negative int32 negates to itself, which is the right magnitude
  assign abs_val = neg ? -int_q : int_q;
  assign is_zero = (abs_val == '0);

  // Priority encoder, the highest set bit wins
  always_comb begin
    lz = '0;
    for (int i = 0; i < `FCVT_INT_W; i++) begin
      if (abs_val[i]) begin
        lz = fcvt_pkg::lz_t'(`FCVT_INT_W - 1 - i);
      end
    end
  end

  // Msb moves to bit 31 and becomes the hidden one
  assign shifted = abs_val << lz;
  assign exp_d   = fcvt_pkg::exp_t'(`FCVT_BIAS + `FCVT_INT_W - 1) - fcvt_pkg::exp_t'(lz);

  // --------------------
  // Interface registers
  // --------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      norm.sign      <= 1'b0;
      norm.exponent  <= '0;
      norm.mantissa  <= '0;
      norm.guard     <= 1'b0;
      norm.round_bit <= 1'b0;
      norm.sticky    <= 1'b0;
    end else if (convert_en) begin
      if (is_zero) begin
        norm.sign      <= 1'b0;
        norm.exponent  <= '0;
        norm.mantissa  <= '0;
        norm.guard     <= 1'b0;
        norm.round_bit <= 1'b0;
        norm.sticky    <= 1'b0;
      end else begin
        norm.sign      <= neg;
        norm.exponent  <= exp_d;
        norm.mantissa  <= shifted[30:8];
        norm.guard     <= shifted[7];
        norm.round_bit <= shifted[6];
        // Anything further down only tells whether the value is exact
        norm.sticky    <= |shifted[5:0];
      end
    end
  end

endmodule

`default_nettype wire

/* hw/fcvt_round.sv */
// Single-precision rounder
// Applies the rounding mode to a normalized value and packs the result

`timescale 1ns/1ps
`default_nettype none

module fcvt_round (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               round_en,
  input  fcvt_pkg::rm_t      rounding_mode,
  fcvt_norm_if.consumer      norm,
  output fcvt_pkg::fp_word_t fp_result,
  output logic               flag_nx
);

  logic                                   any_extra;
  logic                                   round_up;
  logic [$bits(fcvt_pkg::fp_word_t)-2:0]  mag;
  logic [$bits(fcvt_pkg::fp_word_t)-2:0]  mag_rnd;

  // Some bit below the mantissa lsb is set
  assign any_extra = norm.guard || norm.round_bit || norm.sticky;

  // --------------------
  // Round decision
  // --------------------
  always_comb begin
    case (rounding_mode)
      // Nearest with ties to even
      3'd0:    round_up = norm.guard && (norm.round_bit || norm.sticky || norm.mantissa[0]);
      // Toward zero
      3'd1:    round_up = 1'b0;
      // Down grows only a negative magnitude
      3'd2:    round_up = norm.sign && any_extra;
      // Up
      3'd3:    round_up = !norm.sign && any_extra;
      // Nearest with ties away from zero
      3'd4:    round_up = norm.guard;
      default: round_up = 1'b0;
    endcase
  end

  // Carry out of an all-ones mantissa clears it and bumps the exponent
  assign mag     = {norm.exponent, norm.mantissa};
  assign mag_rnd = round_up ? mag + 31'd1 : mag;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      fp_result <= '0;
      flag_nx   <= 1'b0;
    end else if (round_en) begin
      fp_result <= {norm.sign, mag_rnd};
      flag_nx   <= any_extra;
    end
  end

endmodule

`default_nettype wire

/* hw/fcvt_top.sv */
// Int32 / single-precision converter
// Multi-cycle start/done unit covering both directions, signed and unsigned

`timescale 1ns/1ps
`default_nettype none

module fcvt_top (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                start,
  input  fcvt_pkg::cvt_op_t   operation,
  input  fcvt_pkg::rm_t       rounding_mode,
  input  fcvt_pkg::int_word_t int_operand,
  input  fcvt_pkg::fp_word_t  fp_operand,
  output logic                busy,
  output logic                done,
  output fcvt_pkg::int_word_t int_result,
  output fcvt_pkg::fp_word_t  fp_result,
  output logic                flag_nv,
  output logic                flag_nx
);

  logic              accept;
  logic              convert_en;
  logic              round_en;
  fcvt_pkg::cvt_op_t op_q;
  logic              is_i2f;
  logic              f2i_nv;
  logic              f2i_nx;
  logic              rnd_nx;

  fcvt_norm_if norm ();

  fcvt_control i_control (
    .clk        (clk),
    .reset_n    (reset_n),
    .start      (start),
    .operation  (operation),
    .accept     (accept),
    .convert_en (convert_en),
    .round_en   (round_en),
    .busy       (busy),
    .done       (done),
    .op_q       (op_q)
  );

  assign is_i2f = op_q[1];

  // --------------------
  // Datapaths
  // --------------------
  // Each path only updates for its own direction so the other result holds
  fp_to_int i_fp_to_int (
    .clk         (clk),
    .reset_n     (reset_n),
    .accept      (accept),
    .convert_en  (convert_en && !is_i2f),
    .is_unsigned (op_q[0]),
    .fp_operand  (fp_operand),
    .int_result  (int_result),
    .flag_nv     (f2i_nv),
    .flag_nx     (f2i_nx)
  );

  int_to_fp i_int_to_fp (
    .clk         (clk),
    .reset_n     (reset_n),
    .accept      (accept),
    .convert_en  (convert_en && is_i2f),
    .is_unsigned (op_q[0]),
    .int_operand (int_operand),
    .norm        (norm.producer)
  );

  fcvt_round i_round (
    .clk           (clk),
    .reset_n       (reset_n),
    .round_en      (round_en && is_i2f),
    .rounding_mode (rounding_mode),
    .norm          (norm.consumer),
    .fp_result     (fp_result),
    .flag_nx       (rnd_nx)
  );

  // Int32 always fits single precision, so int to float is never invalid
  assign flag_nv = is_i2f ? 1'b0 : f2i_nv;
  assign flag_nx = is_i2f ? rnd_nx : f2i_nx;

endmodule

`default_nettype wire

/* bench/fcvt_model.svh */
// Converter reference model
// Expected results for both conversion directions and the random source

`ifndef FCVT_MODEL_SVH
`define FCVT_MODEL_SVH

// Galois LFSR, one step per random bit
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// Float to int32, returns {nv, nx, result}
function automatic logic [33:0] model_f2i(input logic [31:0] f, input bit uns);
  logic        sign;
  int          e;
  logic [63:0] sig;
  logic [63:0] mag;
  logic [31:0] m;
  logic        lost;
  sign = f[31];
  e    = int'(f[30:23]) - `FCVT_BIAS;
  sig  = {40'h0, 1'b1, f[22:0]};
  if (f[30:23] == 8'hff) begin
    if (uns) return {2'b10, sign ? 32'h0 : `FCVT_UINT_MAX};
    return {2'b10, sign ? `FCVT_INT_MIN : `FCVT_INT_MAX};
  end
  if (f[30:0] == 31'h0) return 34'h0;
  // Magnitude below one truncates to zero
  if (e < 0) return {2'b01, 32'h0};
  if (uns && sign) return {2'b10, 32'h0};
  if (uns && e >= 32) return {2'b10, `FCVT_UINT_MAX};
  if (!uns && e >= 32) return {2'b10, sign ? `FCVT_INT_MIN : `FCVT_INT_MAX};
  if (e >= 23) begin
    mag  = sig << (e - 23);
    lost = 1'b0;
  end else begin
    mag  = sig >> (23 - e);
    lost = (sig & ((64'd1 << (23 - e)) - 64'd1)) != 64'd0;
  end
  m = mag[31:0];
  if (uns) return {1'b0, lost, m};
  // Only -2^31 may reach bit 31 in the signed range
  if (mag > 64'h8000_0000 || (mag == 64'h8000_0000 && !sign)) begin
    return {2'b10, sign ? `FCVT_INT_MIN : `FCVT_INT_MAX};
  end
  return {1'b0, lost, sign ? -m : m};
endfunction

// Int32 to float with rounding, returns {nx, result}
function automatic logic [32:0] model_i2f(input logic [31:0] v, input bit uns,
                                          input logic [2:0] rm);
  logic        sign;
  logic [31:0] m32;
  logic [63:0] mag;
  logic [63:0] rem;
  logic [63:0] half;
  logic [30:0] em;
  int          p;
  int          sh;
  logic        up;
  sign = !uns && v[31];
  m32  = sign ? -v : v;
  mag  = {32'h0, m32};
  if (mag == 64'd0) return 33'h0;
  p = 0;
  while ((mag >> (p + 1)) != 64'd0) p++;
  if (p <= 23) begin
    em = {8'(`FCVT_BIAS + p), 23'(mag << (23 - p))};
    return {1'b0, sign, em};
  end
  sh   = p - 23;
  rem  = mag & ((64'd1 << sh) - 64'd1);
  half = 64'd1 << (sh - 1);
  em   = {8'(`FCVT_BIAS + p), 23'(mag >> sh)};
  case (rm)
    3'd0:    up = rem > half || (rem == half && em[0]);
    3'd2:    up = sign && rem != 64'd0;
    3'd3:    up = !sign && rem != 64'd0;
    3'd4:    up = rem >= half;
    default: up = 1'b0;
  endcase
  if (up) em = em + 31'd1;
  return {rem != 64'd0, sign, em};
endfunction

`endif

/* bench/tb_fcvt.sv */
// Converter testbench
// Random and corner-case conversions in both directions, checked against a model

`timescale 1ns/1ps
`default_nettype none

`include "fcvt_config.svh"

module tb_fcvt;

  localparam int TIMEOUT = 10;

  // Zero, below one, specials and the int32/uint32 range borders
  localparam logic [31:0] FP_EDGE [17] = '{
    32'h0000_0000, 32'h8000_0000, 32'h3f00_0000, 32'hbf7f_ffff, 32'h0000_0001,
    32'h7fc0_0000, 32'hffc0_0000, 32'h7f80_0000, 32'hff80_0000, 32'h4f00_0000,
    32'hcf00_0000, 32'h4f00_0001, 32'hcf00_0001, 32'h4f80_0000, 32'h4f7f_ffff,
    32'hbf80_0000, 32'hbfc0_0000
  };

  // Carries into the exponent and rounding ties
  localparam logic [31:0] RND_EDGE [8] = '{
    32'hffff_ffff, 32'h7fff_ffff, 32'h01ff_ffff, 32'hfe00_0001,
    32'h0100_0001, 32'h0100_0003, 32'h0300_0002, 32'hffff_ff80
  };

  logic                clk;
  logic                reset_n;
  logic                start;
  fcvt_pkg::cvt_op_t   operation;
  fcvt_pkg::rm_t       rounding_mode;
  fcvt_pkg::int_word_t int_operand;
  fcvt_pkg::fp_word_t  fp_operand;
  logic                busy;
  logic                done;
  fcvt_pkg::int_word_t int_result;
  fcvt_pkg::fp_word_t  fp_result;
  logic                flag_nv;
  logic                flag_nx;
  int                  errors;
  int                  timeouts;
  logic [31:0]         lfsr;

  `include "fcvt_model.svh"

  fcvt_top i_dut (
    .clk           (clk),
    .reset_n       (reset_n),
    .start         (start),
    .operation     (operation),
    .rounding_mode (rounding_mode),
    .int_operand   (int_operand),
    .fp_operand    (fp_operand),
    .busy          (busy),
    .done          (done),
    .int_result    (int_result),
    .fp_result     (fp_result),
    .flag_nv       (flag_nv),
    .flag_nx       (flag_nx)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_reset_outputs(input string name);
    check_value({name, " busy"}, 0, 32'(busy));
    check_value({name, " done"}, 0, 32'(done));
    check_value({name, " flag_nv"}, 0, 32'(flag_nv));
    check_value({name, " flag_nx"}, 0, 32'(flag_nx));
    check_value({name, " int_result"}, 0, int_result);
    check_value({name, " fp_result"}, 0, fp_result);
  endtask

  // --------------------
  // One conversion, start to done
  // --------------------
  task automatic run_op(input string name, input fcvt_pkg::cvt_op_t op,
                        input fcvt_pkg::rm_t rm, input logic [31:0] value,
                        input bit restart);
    int          cycles;
    logic [33:0] f2i_exp;
    logic [32:0] i2f_exp;
    if (timeouts != 0) return;
    @(negedge clk);
    operation     = op;
    rounding_mode = rm;
    int_operand   = value;
    fp_operand    = value;
    start         = 1'b1;
    @(negedge clk);
    // A second start while busy must not disturb the captured operand
    start = restart;
    if (restart) begin
      int_operand = ~value;
      fp_operand  = ~value;
    end
    cycles = 1;
    while (!done && cycles < TIMEOUT) begin
      if (!busy) begin
        $display("%s: busy is low %0d cycles after start", name, cycles);
        errors++;
      end
      @(negedge clk);
      cycles++;
    end
    start = 1'b0;
    if (!done) begin
      $display("%s: no done within %0d cycles", name, TIMEOUT);
      timeouts++;
      return;
    end
    check_value({name, " latency"}, 32'd3, 32'(cycles));
    check_value({name, " busy at done"}, 0, 32'(busy));
    if (op[1]) begin
      i2f_exp = model_i2f(value, op[0], rm);
      check_value({name, " fp_result"}, i2f_exp[31:0], fp_result);
      check_value({name, " flag_nx"}, 32'(i2f_exp[32]), 32'(flag_nx));
      check_value({name, " flag_nv"}, 0, 32'(flag_nv));
    end else begin
      f2i_exp = model_f2i(value, op[0]);
      check_value({name, " int_result"}, f2i_exp[31:0], int_result);
      check_value({name, " flag_nx"}, 32'(f2i_exp[32]), 32'(flag_nx));
      check_value({name, " flag_nv"}, 32'(f2i_exp[33]), 32'(flag_nv));
    end
    // Done is a single pulse
    repeat (3) begin
      @(negedge clk);
      check_value({name, " done after pulse"}, 0, 32'(done));
    end
  endtask

  initial begin
    logic [31:0] value;
    clk           = 1'b0;
    reset_n       = 1'b0;
    start         = 1'b0;
    operation     = fcvt_pkg::FCVT_W_S;
    rounding_mode = '0;
    int_operand   = '0;
    fp_operand    = '0;
    errors        = 0;
    timeouts      = 0;
    lfsr          = 32'hafef_63e9;
    repeat (5) @(negedge clk);
    check_reset_outputs("in reset");
    reset_n = 1'b1;
    @(negedge clk);
    check_reset_outputs("after reset");

    // Float to int, corners then random
    for (int k = 0; k < 17; k++) begin
      run_op($sformatf("f2i edge s %h", FP_EDGE[k]), fcvt_pkg::FCVT_W_S, 3'd0, FP_EDGE[k], 1'b0);
      run_op($sformatf("f2i edge u %h", FP_EDGE[k]), fcvt_pkg::FCVT_WU_S, 3'd0, FP_EDGE[k], 1'b0);
    end
    for (int k = 0; k < 300; k++) begin
      value = rand_bits(32);
      // Most exponents near the int32 range
      if (k % 4 != 0) value[30:23] = 8'(100 + rand_bits(6));
      run_op($sformatf("f2i rand s %h", value), fcvt_pkg::FCVT_W_S, 3'd0, value, 1'b0);
      run_op($sformatf("f2i rand u %h", value), fcvt_pkg::FCVT_WU_S, 3'd0, value, 1'b0);
    end

    // --------------------
    // Int to float, exact
    // --------------------
    run_op("i2f exact s zero", fcvt_pkg::FCVT_S_W, 3'd0, 32'h0, 1'b0);
    run_op("i2f exact u zero", fcvt_pkg::FCVT_S_WU, 3'd0, 32'h0, 1'b0);
    run_op("i2f exact s int_min", fcvt_pkg::FCVT_S_W, 3'd0, 32'h8000_0000, 1'b0);
    run_op("i2f exact u 2^31", fcvt_pkg::FCVT_S_WU, 3'd0, 32'h8000_0000, 1'b0);
    run_op("i2f exact u top", fcvt_pkg::FCVT_S_WU, 3'd3, 32'hffff_ff00, 1'b0);
    run_op("i2f exact s neg", fcvt_pkg::FCVT_S_W, 3'd2, 32'hff00_0001, 1'b0);
    for (int k = 0; k < 200; k++) begin
      value = rand_bits(24) << rand_bits(3);
      if (rand_bits(1) == 1) value = -value;
      run_op($sformatf("i2f exact s %h", value), fcvt_pkg::FCVT_S_W, 3'(rand_bits(3)), value,
             1'b0);
      value = rand_bits(24) << rand_bits(3);
      if (rand_bits(1) == 1) value = value << 1;
      run_op($sformatf("i2f exact u %h", value), fcvt_pkg::FCVT_S_WU, 3'(rand_bits(3)), value,
             1'b0);
    end

    // Int to float, every rounding mode
    for (int k = 0; k < 158; k++) begin
      value = (k < 8) ? RND_EDGE[k] : (rand_bits(32) >> rand_bits(3));
      for (int m = 0; m < 8; m++) begin
        run_op($sformatf("i2f rm%0d s %h", m, value), fcvt_pkg::FCVT_S_W, 3'(m), value, 1'b0);
        run_op($sformatf("i2f rm%0d u %h", m, value), fcvt_pkg::FCVT_S_WU, 3'(m), value, 1'b0);
      end
    end

    // Start while busy
    for (int k = 0; k < 12; k++) begin
      value = rand_bits(32);
      run_op($sformatf("busy start op%0d %h", k % 4, value), fcvt_pkg::cvt_op_t'(k % 4),
             3'(rand_bits(3)), value, 1'b1);
    end

    $display("Closing counts: %0d check errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hw
+incdir+bench
hw/fcvt_pkg.sv
hw/fcvt_norm_if.sv
hw/fcvt_control.sv
hw/fp_to_int.sv
hw/int_to_fp.sv
hw/fcvt_round.sv
hw/fcvt_top.sv
bench/tb_fcvt.sv

/* run.sh */
#!/bin/sh
# Builds the converter testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --top-module tb_fcvt -f verilog.f
./obj_dir/Vtb_fcvt | tee sim.log

if grep -q "Finished with errors" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
